/* verilog/oooParams.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// ============================================================================
// Core sizing
// ============================================================================

// Architectural integer registers
`define OOO_NUM_REGS 16

// Reorder buffer slots, power of two so the wrap bit works
`define OOO_ROB_DEPTH 8

// Width of every data value
`define OOO_DATA_WIDTH 32

`endif

/* verilog/oooPkg.sv */
`default_nettype none

`include "oooParams.svh"

package oooPkg;

    // Architectural register number
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] regIdx_t;

    // Reorder buffer slot index
    typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0] robTag_t;

    // Slot index with a wrap bit on top, tells full from empty
    typedef logic [$clog2(`OOO_ROB_DEPTH):0] robPtr_t;

    typedef logic [`OOO_DATA_WIDTH-1:0] word_t;   // Data value

endpackage

`default_nettype wire

/* verilog/reorderBuffer.sv */
`default_nettype none

`include "oooParams.svh"

module reorderBuffer
    import oooPkg::*;
(
    input  logic    CLK,
    input  logic    Reset,

    input  logic    Append,
    input  regIdx_t AppendReg,

    input  logic    DpValid,
    input  robTag_t DpTag,
    input  word_t   DpValue,
    input  logic    DpWriteBack,
    input  logic    MemValid,
    input  robTag_t MemTag,
    input  word_t   MemValue,
    input  logic    MemWriteBack,
    input  logic    MulValid,
    input  robTag_t MulTag,
    input  word_t   MulValue,
    input  logic    FpValid,
    input  robTag_t FpTag,
    input  word_t   FpValue,

    input  robTag_t LookupTagA,
    input  robTag_t LookupTagB,

    output logic    Full,
    output robTag_t TailTag,
    output robTag_t HeadTag,
    output logic    ForwardReadyA,
    output logic    ForwardReadyB,
    output word_t   ForwardValueA,
    output word_t   ForwardValueB,

    output logic    Commit,
    output regIdx_t CommitReg,
    output logic    CommitWrite,
    output word_t   CommitValue
);

    robPtr_t head;
    robPtr_t tail;

    logic [`OOO_ROB_DEPTH-1:0] busy;
    logic [`OOO_ROB_DEPTH-1:0] finished;
    logic [`OOO_ROB_DEPTH-1:0] writeFlag;
    regIdx_t                   destReg [`OOO_ROB_DEPTH];
    word_t                     value   [`OOO_ROB_DEPTH];

    // Lanes in priority order, index 0 is Dp and index 3 is Fp
    logic [3:0] laneValid;
    logic [3:0] laneWrite;
    robTag_t    laneTag   [4];
    word_t      laneValue [4];

    logic retire;

    // ========================================================================
    // Pointers and status
    // ========================================================================

    assign HeadTag = robTag_t'(head);
    assign TailTag = robTag_t'(tail);

    // Same slot, opposite wrap bit
    assign Full = (head == {~tail[$bits(robTag_t)], TailTag});

    assign laneValid = {FpValid, MulValid, MemValid, DpValid};
    assign laneWrite = {1'b0, 1'b1, MemWriteBack, DpWriteBack};   // Mul always, Fp never
    assign laneTag   = '{DpTag, MemTag, MulTag, FpTag};
    assign laneValue = '{DpValue, MemValue, MulValue, FpValue};

    // An empty slot is never busy, so no separate empty check
    assign retire = busy[HeadTag] & finished[HeadTag];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            head     <= '0;
            tail     <= '0;
            busy     <= '0;
            finished <= '0;
        end else begin
            if (retire) begin
                busy[HeadTag] <= 1'b0;
                head          <= head + 1'b1;
            end
            for (int i = 0; i < 4; i++) begin
                if (laneValid[i] && busy[laneTag[i]]) begin
                    finished[laneTag[i]] <= 1'b1;
                end
            end
            if (Append) begin   // Caller never appends while full
                busy[TailTag]     <= 1'b1;
                finished[TailTag] <= 1'b0;
                tail              <= tail + 1'b1;
            end
        end
    end

    // ========================================================================
    // Entry payload
    // ========================================================================

    always_ff @(posedge CLK) begin
        if (Append) begin
            destReg[TailTag] <= AppendReg;
        end
        // Later lane overwrites an earlier one on the same tag
        for (int i = 0; i < 4; i++) begin
            if (laneValid[i] && busy[laneTag[i]]) begin
                value[laneTag[i]]     <= laneValue[i];
                writeFlag[laneTag[i]] <= laneWrite[i];
            end
        end
    end

    // ========================================================================
    // Commit and forwarding
    // ========================================================================

    always_comb begin
        Commit      = retire;
        CommitReg   = '0;
        CommitWrite = 1'b0;
        CommitValue = '0;
        if (retire) begin
            CommitReg   = destReg[HeadTag];
            CommitWrite = writeFlag[HeadTag];
            CommitValue = value[HeadTag];
        end
    end

    assign ForwardReadyA = busy[LookupTagA] & finished[LookupTagA];
    assign ForwardReadyB = busy[LookupTagB] & finished[LookupTagB];
    assign ForwardValueA = value[LookupTagA];
    assign ForwardValueB = value[LookupTagB];

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`default_nettype none

`include "oooParams.svh"

module registerFile
    import oooPkg::*;
(
    input  logic    CLK,
    input  logic    Reset,
    input  logic    WriteEnable,
    input  regIdx_t WriteReg,
    input  word_t   WriteData,
    input  regIdx_t ReadRegA,
    input  regIdx_t ReadRegB,
    output word_t   ReadDataA,
    output word_t   ReadDataB
);

    word_t regs [`OOO_NUM_REGS];

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (WriteEnable) begin
            regs[WriteReg] <= WriteData;
        end
    end

    // Old value until the edge, no write bypass
    assign ReadDataA = regs[ReadRegA];
    assign ReadDataB = regs[ReadRegB];

endmodule

`default_nettype wire

/* verilog/renameTable.sv */
`default_nettype none

`include "oooParams.svh"

module renameTable
    import oooPkg::*;
(
    input  logic    CLK,
    input  logic    Reset,

    input  logic    Rename,
    input  regIdx_t RenameReg,
    input  robTag_t RenameTag,

    input  logic    Retire,
    input  regIdx_t RetireReg,
    input  robTag_t RetireTag,

    input  regIdx_t LookupRegA,
    input  regIdx_t LookupRegB,
    output logic    BusyA,
    output logic    BusyB,
    output robTag_t TagA,
    output robTag_t TagB
);

    logic [`OOO_NUM_REGS-1:0] busy;
    robTag_t                  owner [`OOO_NUM_REGS];

    // Clear only if the retiring entry is still the newest producer
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            busy <= '0;
        end else begin
            if (Retire && busy[RetireReg] && owner[RetireReg] == RetireTag) begin
                busy[RetireReg] <= 1'b0;
            end
            if (Rename) begin
                busy[RenameReg] <= 1'b1;   // Wins over a clear of the same register
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (Rename) begin
            owner[RenameReg] <= RenameTag;
        end
    end

    assign BusyA = busy[LookupRegA];
    assign BusyB = busy[LookupRegB];
    assign TagA  = owner[LookupRegA];
    assign TagB  = owner[LookupRegB];

endmodule

`default_nettype wire

/* verilog/dispatchStage.sv */
`default_nettype none

module dispatchStage
    import oooPkg::*;
(
    input  logic    Dispatch,
    input  logic    Full,

    input  logic    BusyA,
    input  logic    BusyB,
    input  robTag_t TagA,
    input  robTag_t TagB,
    input  word_t   RegDataA,
    input  word_t   RegDataB,
    input  logic    ForwardReadyA,
    input  logic    ForwardReadyB,
    input  word_t   ForwardValueA,
    input  word_t   ForwardValueB,

    output logic    Append,
    output robTag_t LookupTagA,
    output robTag_t LookupTagB,
    output word_t   OperandA,
    output word_t   OperandB,
    output logic    OperandReadyA,
    output logic    OperandReadyB,
    output robTag_t OperandTagA,
    output robTag_t OperandTagB
);

    // Ready from the register file or from a finished entry
    function automatic logic operandReady(input logic busy, input logic fwdReady);
        return !busy || fwdReady;
    endfunction

    function automatic word_t operandValue(
        input logic  busy,
        input logic  fwdReady,
        input word_t regData,
        input word_t fwdValue
    );
        if (!busy) begin
            return regData;
        end
        return fwdReady ? fwdValue : '0;
    endfunction

    // Tag only carries meaning while the operand is pending
    function automatic robTag_t operandTag(
        input logic    busy,
        input logic    fwdReady,
        input robTag_t tag
    );
        return (busy && !fwdReady) ? tag : '0;
    endfunction

    assign Append = Dispatch & ~Full;   // Dropped while full

    // Producer lookup follows the rename mapping
    assign LookupTagA = TagA;
    assign LookupTagB = TagB;

    assign OperandReadyA = operandReady(BusyA, ForwardReadyA);
    assign OperandReadyB = operandReady(BusyB, ForwardReadyB);

    assign OperandA = operandValue(BusyA, ForwardReadyA, RegDataA, ForwardValueA);
    assign OperandB = operandValue(BusyB, ForwardReadyB, RegDataB, ForwardValueB);

    assign OperandTagA = operandTag(BusyA, ForwardReadyA, TagA);
    assign OperandTagB = operandTag(BusyB, ForwardReadyB, TagB);

endmodule

`default_nettype wire

/* verilog/oooBackEnd.sv */
`default_nettype none

module oooBackEnd
    import oooPkg::*;
(
    input  logic    CLK,
    input  logic    Reset,

    input  logic    Dispatch,
    input  regIdx_t DestReg,
    input  regIdx_t SrcRegA,
    input  regIdx_t SrcRegB,

    input  logic    DpValid,
    input  robTag_t DpTag,
    input  word_t   DpValue,
    input  logic    DpWriteBack,
    input  logic    MemValid,
    input  robTag_t MemTag,
    input  word_t   MemValue,
    input  logic    MemWriteBack,
    input  logic    MulValid,
    input  robTag_t MulTag,
    input  word_t   MulValue,
    input  logic    FpValid,
    input  robTag_t FpTag,
    input  word_t   FpValue,

    output logic    Full,
    output robTag_t DispatchTag,
    output word_t   OperandA,
    output word_t   OperandB,
    output logic    OperandReadyA,
    output logic    OperandReadyB,
    output robTag_t OperandTagA,
    output robTag_t OperandTagB,

    output logic    Commit,
    output regIdx_t CommitReg,
    output logic    CommitWrite,
    output word_t   CommitValue
);

    logic    append;
    robTag_t headTag;
    logic    busyA, busyB;
    robTag_t tagA, tagB;
    robTag_t lookupTagA, lookupTagB;
    word_t   regDataA, regDataB;
    logic    fwdReadyA, fwdReadyB;
    word_t   fwdValueA, fwdValueB;

    // ========================================================================
    // Dispatch side
    // ========================================================================

    dispatchStage uDispatch (
        .Dispatch(Dispatch), .Full(Full),
        .BusyA(busyA), .BusyB(busyB), .TagA(tagA), .TagB(tagB),
        .RegDataA(regDataA), .RegDataB(regDataB),
        .ForwardReadyA(fwdReadyA), .ForwardReadyB(fwdReadyB),
        .ForwardValueA(fwdValueA), .ForwardValueB(fwdValueB),
        .Append(append), .LookupTagA(lookupTagA), .LookupTagB(lookupTagB),
        .OperandA(OperandA), .OperandB(OperandB),
        .OperandReadyA(OperandReadyA), .OperandReadyB(OperandReadyB),
        .OperandTagA(OperandTagA), .OperandTagB(OperandTagB)
    );

    renameTable uRename (
        .CLK(CLK), .Reset(Reset),
        .Rename(append), .RenameReg(DestReg), .RenameTag(DispatchTag),
        .Retire(Commit), .RetireReg(CommitReg), .RetireTag(headTag),
        .LookupRegA(SrcRegA), .LookupRegB(SrcRegB),
        .BusyA(busyA), .BusyB(busyB), .TagA(tagA), .TagB(tagB)
    );

    // CommitWrite is already low outside a commit
    registerFile uRegFile (
        .CLK(CLK), .Reset(Reset),
        .WriteEnable(CommitWrite), .WriteReg(CommitReg), .WriteData(CommitValue),
        .ReadRegA(SrcRegA), .ReadRegB(SrcRegB),
        .ReadDataA(regDataA), .ReadDataB(regDataB)
    );

    // ========================================================================
    // Reorder buffer
    // ========================================================================

    reorderBuffer uRob (
        .CLK(CLK), .Reset(Reset),
        .Append(append), .AppendReg(DestReg),
        .DpValid(DpValid), .DpTag(DpTag), .DpValue(DpValue), .DpWriteBack(DpWriteBack),
        .MemValid(MemValid), .MemTag(MemTag), .MemValue(MemValue),
        .MemWriteBack(MemWriteBack),
        .MulValid(MulValid), .MulTag(MulTag), .MulValue(MulValue),
        .FpValid(FpValid), .FpTag(FpTag), .FpValue(FpValue),
        .LookupTagA(lookupTagA), .LookupTagB(lookupTagB),
        .Full(Full), .TailTag(DispatchTag), .HeadTag(headTag),
        .ForwardReadyA(fwdReadyA), .ForwardReadyB(fwdReadyB),
        .ForwardValueA(fwdValueA), .ForwardValueB(fwdValueB),
        .Commit(Commit), .CommitReg(CommitReg),
        .CommitWrite(CommitWrite), .CommitValue(CommitValue)
    );

endmodule

`default_nettype wire

/* dv/oooBackEndTb.sv */
`default_nettype none

`include "oooParams.svh"

module oooBackEndTb
    import oooPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    logic    CLK, Reset, Dispatch;
    regIdx_t DestReg, SrcRegA, SrcRegB;
    logic    DpValid, DpWriteBack, MemValid, MemWriteBack, MulValid, FpValid;
    robTag_t DpTag, MemTag, MulTag, FpTag;
    word_t   DpValue, MemValue, MulValue, FpValue;
    logic    Full, OperandReadyA, OperandReadyB, Commit, CommitWrite;
    robTag_t DispatchTag, OperandTagA, OperandTagB;
    word_t   OperandA, OperandB, CommitValue;
    regIdx_t CommitReg;

    // Reference model state
    word_t   refReg     [`OOO_NUM_REGS];
    logic    refBusy    [`OOO_NUM_REGS];
    robTag_t refOwner   [`OOO_NUM_REGS];
    logic    refEntBusy [`OOO_ROB_DEPTH];
    logic    refFin     [`OOO_ROB_DEPTH];
    logic    refWr      [`OOO_ROB_DEPTH];
    regIdx_t refDest    [`OOO_ROB_DEPTH];
    word_t   refVal     [`OOO_ROB_DEPTH];
    robPtr_t refHead, refTail;

    // Current row, lanes indexed Dp, Mem, Mul, Fp
    logic       stepDisp, stepCommit, stepFull;
    regIdx_t    stepDest, stepSrcA, stepSrcB;
    logic [3:0] stepLanes;
    logic [1:0] stepWb;
    robTag_t    stepTag [4];
    word_t      laneVal [4];
    logic       laneWr  [4];

    logic [32:0] rows [$];
    int          rowTest [$];
    string       testNames [5] = '{"reset", "in-order commit", "lane write rules",
                                   "rename versus retire", "full"};
    int          curTest, curRow, errorCount, testErrors, testsRun, testsPassed;
    int          cycles, cycleLimit;
    logic [31:0] lfsr = 32'h8de5_b5dd;

    oooBackEnd DUT (.*);

    always #4 CLK = ~CLK;

    // ========================================================================
    // Stimulus helpers
    // ========================================================================

    function automatic logic lfsrBit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out)
            lfsr = lfsr ^ 32'h8020_0003;   // Galois taps 32, 22, 2, 1
        return out;
    endfunction

    function automatic word_t randWord();
        word_t w;
        w = '0;
        for (int b = 0; b < `OOO_DATA_WIDTH; b++)
            w = {w[`OOO_DATA_WIDTH-2:0], lfsrBit()};
        return w;
    endfunction

    task automatic addStep(input int d, input int dst, input int sa, input int sb, input int lv,
                           input int dpT, input int memT, input int mulT, input int fpT,
                           input int wb, input int cm, input int fl);
        rows.push_back({1'(d), 4'(dst), 4'(sa), 4'(sb), 4'(lv), 3'(dpT), 3'(memT), 3'(mulT),
                        3'(fpT), 2'(wb), 1'(cm), 1'(fl)});
        rowTest.push_back(curTest);
    endtask

    task automatic driveStep();
        for (int k = 0; k < 4; k++)
            laneVal[k] = stepLanes[k] ? randWord() : '0;
        laneWr[0] = stepWb[0];
        laneWr[1] = stepWb[1];
        laneWr[2] = 1'b1;   // Mul always writes
        laneWr[3] = 1'b0;
        Dispatch     = stepDisp;
        DestReg      = stepDest;
        SrcRegA      = stepSrcA;
        SrcRegB      = stepSrcB;
        DpValid      = stepLanes[0];
        DpTag        = stepTag[0];
        DpValue      = laneVal[0];
        DpWriteBack  = stepWb[0];
        MemValid     = stepLanes[1];
        MemTag       = stepTag[1];
        MemValue     = laneVal[1];
        MemWriteBack = stepWb[1];
        MulValid     = stepLanes[2];
        MulTag       = stepTag[2];
        MulValue     = laneVal[2];
        FpValid      = stepLanes[3];
        FpTag        = stepTag[3];
        FpValue      = laneVal[3];
    endtask

    // ========================================================================
    // Reference model and checks
    // ========================================================================

    task automatic resetModel();
        for (int r = 0; r < `OOO_NUM_REGS; r++) begin
            refReg[r]   = '0;
            refBusy[r]  = 1'b0;
            refOwner[r] = '0;
        end
        for (int e = 0; e < `OOO_ROB_DEPTH; e++) begin
            refEntBusy[e] = 1'b0;
            refFin[e]     = 1'b0;
        end
        refHead = '0;
        refTail = '0;
    endtask

    task automatic applyEdge();
        robTag_t h;
        robTag_t t;
        regIdx_t r;
        logic    full;
        h = robTag_t'(refHead);
        t = robTag_t'(refTail);
        r = refDest[h];
        full = robPtr_t'(refTail - refHead) == robPtr_t'(`OOO_ROB_DEPTH);   // Before this commit
        if (refEntBusy[h] && refFin[h]) begin
            if (refWr[h])
                refReg[r] = refVal[h];
            if (refBusy[r] && refOwner[r] == h)
                refBusy[r] = 1'b0;   // Rename below still wins
            refEntBusy[h] = 1'b0;
            refHead       = refHead + 1'b1;
        end
        for (int k = 0; k < 4; k++) begin   // Later lane wins on a shared tag
            if (stepLanes[k] && refEntBusy[stepTag[k]]) begin
                refFin[stepTag[k]] = 1'b1;
                refVal[stepTag[k]] = laneVal[k];
                refWr[stepTag[k]]  = laneWr[k];
            end
        end
        if (stepDisp && !full) begin
            refEntBusy[t]     = 1'b1;
            refFin[t]         = 1'b0;
            refDest[t]        = stepDest;
            refBusy[stepDest] = 1'b1;
            refOwner[stepDest] = t;
            refTail           = refTail + 1'b1;
        end
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("Mismatch at %0t: row %0d %s is %h, expected %h",
                 $time, curRow, what, got, exp);
        errorCount++;
        testErrors++;
    endtask

    task automatic checkOperand(input string side, input regIdx_t src, input word_t val,
                                input logic rdy, input robTag_t tag);
        robTag_t owner;
        logic    expRdy;
        word_t   expVal;
        owner  = refOwner[src];
        expRdy = !refBusy[src] || refFin[owner];
        expVal = !refBusy[src] ? refReg[src] : refVal[owner];
        if (rdy !== expRdy)
            reportMismatch({"OperandReady", side}, 32'(rdy), 32'(expRdy));
        if (expRdy && val !== expVal)
            reportMismatch({"Operand", side}, val, expVal);
        if (!expRdy && tag !== owner)
            reportMismatch({"OperandTag", side}, 32'(tag), 32'(owner));
    endtask

    task automatic checkRow();
        robTag_t h;
        h = robTag_t'(refHead);
        if (Commit !== stepCommit)
            reportMismatch("Commit", 32'(Commit), 32'(stepCommit));
        if (stepCommit) begin
            if (CommitReg !== refDest[h])
                reportMismatch("CommitReg", 32'(CommitReg), 32'(refDest[h]));
            if (CommitWrite !== refWr[h])
                reportMismatch("CommitWrite", 32'(CommitWrite), 32'(refWr[h]));
            if (CommitValue !== refVal[h])
                reportMismatch("CommitValue", CommitValue, refVal[h]);
        end
        if (Full !== stepFull)
            reportMismatch("Full", 32'(Full), 32'(stepFull));
        if (DispatchTag !== robTag_t'(refTail))
            reportMismatch("DispatchTag", 32'(DispatchTag), 32'(robTag_t'(refTail)));
        checkOperand("A", stepSrcA, OperandA, OperandReadyA, OperandTagA);
        checkOperand("B", stepSrcB, OperandB, OperandReadyB, OperandTagB);
    endtask

    // ========================================================================
    // Step table
    // ========================================================================

    // Columns: dispatch dest srcA srcB lanes dpTag memTag mulTag fpTag writeBack commit full
    task automatic buildTable();
        curTest = 0;
        addStep(0, 0, 5, 12, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        curTest = 1;
        addStep(1, 1, 0, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(1, 2, 1, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(1, 3, 2, 1, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(0, 0, 2, 3, 'b0110, 0, 1, 2, 0, 'b10, 0, 0);   // Younger ones finish first
        addStep(0, 0, 2, 3, 'b0001, 0, 0, 0, 0, 'b01, 0, 0);
        addStep(0, 0, 1, 2, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 1, 2, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 1, 3, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 2, 3, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        curTest = 2;
        addStep(1, 1, 0, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(1, 2, 0, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(1, 3, 0, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(1, 7, 0, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(0, 0, 1, 2, 'b1111, 3, 5, 6, 4, 'b00, 0, 0);
        addStep(0, 0, 1, 2, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 3, 7, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 1, 2, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 3, 7, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 1, 2, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(0, 0, 3, 7, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(1, 8, 0, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(0, 0, 8, 0, 'b0111, 7, 7, 7, 0, 'b11, 0, 0);   // Three lanes on one tag
        addStep(0, 0, 8, 0, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 8, 3, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        curTest = 3;
        addStep(1, 3, 0, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(0, 0, 3, 0, 'b0001, 0, 0, 0, 0, 'b01, 0, 0);
        addStep(1, 3, 3, 0, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);   // Re-dispatch during commit
        addStep(0, 0, 3, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(0, 0, 3, 0, 'b0100, 0, 0, 1, 0, 'b00, 0, 0);
        addStep(0, 0, 3, 0, 'b0000, 0, 0, 0, 0, 'b00, 1, 0);
        addStep(0, 0, 3, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        curTest = 4;
        for (int i = 0; i < `OOO_ROB_DEPTH; i++)
            addStep(1, 9 + i, 9 + i, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(1, 5, 9, 0, 'b0000, 0, 0, 0, 0, 'b00, 0, 1);
        addStep(0, 0, 9, 10, 'b0100, 0, 0, 2, 0, 'b00, 0, 1);
        addStep(1, 5, 9, 10, 'b0000, 0, 0, 0, 0, 'b00, 1, 1);
        addStep(1, 5, 9, 10, 'b0000, 0, 0, 0, 0, 'b00, 0, 0);
        addStep(0, 0, 5, 9, 'b0000, 0, 0, 0, 0, 'b00, 0, 1);
    endtask

    // ========================================================================
    // Run
    // ========================================================================

    initial begin
        CLK      = 1'b0;
        Reset    = 1'b1;
        stepDisp = 1'b0;
        stepDest = '0;
        stepSrcA = '0;
        stepSrcB = '0;
        stepLanes = '0;
        stepWb   = '0;
        for (int k = 0; k < 4; k++)
            stepTag[k] = '0;
        driveStep();
        resetModel();
        buildTable();
        cycleLimit = 20 * rows.size();
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        Reset = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            curRow = i;
            {stepDisp, stepDest, stepSrcA, stepSrcB, stepLanes, stepTag[0], stepTag[1],
             stepTag[2], stepTag[3], stepWb, stepCommit, stepFull} = rows[i];
            @(negedge CLK);
            driveStep();
            #2;   // Combinational outputs settled, edge still 2 ns away
            checkRow();
            applyEdge();
            if (i == rows.size() - 1 || rowTest[i + 1] != rowTest[i]) begin
                $display("Test %0d (%s): %s, %0d mismatches", rowTest[i],
                         testNames[rowTest[i]], testErrors == 0 ? "passed" : "failed",
                         testErrors);
                if (testErrors == 0)
                    testsPassed++;
                testsRun++;
                testErrors = 0;
            end
        end
        $display("Tests run %0d, passed %0d, failed %0d, mismatches %0d",
                 testsRun, testsPassed, testsRun - testsPassed, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycleLimit != 0 && cycles > cycleLimit) begin
            $display("Timeout: the run did not end within %0d cycles", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+verilog
verilog/oooPkg.sv
verilog/reorderBuffer.sv
verilog/registerFile.sv
verilog/renameTable.sv
verilog/dispatchStage.sv
verilog/oooBackEnd.sv
dv/oooBackEndTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f tb.f --top-module oooBackEndTb -o oooBackEndSim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/oooBackEndSim > sim.log 2>&1
cat sim.log

grep -qx "ALL CHECKS PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
